//--- Makefile
TOOL       := verilator
TOP        := icache_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
SIM_BIN    := icache_sim
COMMON     := --timing --timescale 1ns/10ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary --assert -j 0 --Mdir $(BUILD_DIR) -o $(SIM_BIN)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) $(COMMON)

# the simulator exit status carries pass or fail
sim:
	$(TOOL) $(SIM_FLAGS) $(COMMON)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- project.f
verilog/icache_pkg.sv
verilog/icache_fill_fsm.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_lookup.sv
verilog/icache_top.sv
verification/icache_tb.sv

//--- verification/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req_valid;
    logic              req_ready;
    cpu_req_t          req;
    logic              rsp_valid;
    logic              rsp_ready;
    cpu_rsp_t          rsp;
    logic              memory_read_en;
    logic [addr_w-1:0] memory_address;
    logic              memory_data_valid = 1'b0; // owned by the memory model
    logic [data_w-1:0] memory_data       = '0;

    int          cyc = 0;           // edge counter updated with nba so all readers agree
    int          reads_total = 0;   // word reads seen on the memory port
    int          burst_cnt = 0;     // reads of the current fill so far
    cache_addr_u cur_addr;          // request in flight for the expected block base
    logic [31:0] mem_lcg  = 32'd42530;
    logic [31:0] stim_lcg = 32'd42530;

    logic [addr_w-1:0] ret_addr_q[$]; // reads waiting for their data
    int                ret_due_q[$];  // edge at which each one is returned

    always #20 clk = ~clk; // 40 ns period

    always @(posedge clk) cyc <= cyc + 1;

    icache_top icache_top_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_valid         (req_valid),
        .req_ready         (req_ready),
        .req               (req),
        .rsp_valid         (rsp_valid),
        .rsp_ready         (rsp_ready),
        .rsp               (rsp),
        .memory_read_en    (memory_read_en),
        .memory_address    (memory_address),
        .memory_data_valid (memory_data_valid),
        .memory_data       (memory_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // every address holds a word derived from itself
    function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] a);
        return a ^ 16'hA5C3;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_rsp(input string name, input cpu_rsp_t got, input cpu_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR t=%0t %s: got data=%h hit=%b, expected data=%h hit=%b",
                                $time, name, got.data, got.hit, exp.data, exp.hit));
        end
    endtask

    task automatic check_mem_addr(input cache_addr_u got, input cache_addr_u exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR t=%0t memory_address: got %h, expected %h",
                                $time, got.raw, exp.raw));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR t=%0t %s: got %b, expected %b", $time, name, got, exp));
        end
    endtask

    // memory model returns words in order after 1 to 4 cycles
    always @(posedge clk) begin : mem_model
        int          lat;
        int          due;
        cache_addr_u exp_addr;
        cache_addr_u got_addr;
        if (!rst_n) begin
            ret_addr_q.delete();
            ret_due_q.delete();
            burst_cnt = 0;
            memory_data_valid <= 1'b0;
            memory_data       <= '0;
        end else begin
            if (memory_read_en) begin
                if (burst_cnt >= words_per_block) begin
                    abort_run("more than eight memory reads for one fill");
                end else begin
                    // 16 byte block base plus two bytes per word
                    exp_addr.raw = (cur_addr.raw & ~16'h000F) + 16'(2 * burst_cnt);
                    got_addr.raw = memory_address;
                    check_mem_addr(got_addr, exp_addr);
                    burst_cnt   = burst_cnt + 1;
                    reads_total = reads_total + 1;
                    mem_lcg = lcg_next(mem_lcg);
                    lat = 1 + int'(mem_lcg[17:16]);
                    due = cyc + lat - 1; // driven at this edge means valid next cycle
                    if (ret_due_q.size() != 0 && due <= ret_due_q[$]) begin
                        due = ret_due_q[$] + 1; // keep issue order with one word per cycle
                    end
                    ret_addr_q.push_back(memory_address);
                    ret_due_q.push_back(due);
                end
            end else if (burst_cnt > 0 && burst_cnt < words_per_block) begin
                abort_run("memory reads of a fill not on consecutive cycles");
            end else begin
                burst_cnt = 0; // fill burst over
            end
            if (ret_due_q.size() != 0 && ret_due_q[0] == cyc) begin
                memory_data_valid <= 1'b1;
                memory_data       <= mem_word(ret_addr_q[0]);
                void'(ret_addr_q.pop_front());
                void'(ret_due_q.pop_front());
            end else begin
                memory_data_valid <= 1'b0;
            end
        end
    end

    // runs one request through the cache right after a rising edge
    task automatic run_request(input cache_addr_u addr, input cpu_rsp_t exp_rsp);
        int       waited;
        int       acc_cyc;
        int       first_cyc;
        int       reads_at_issue;
        int       stall;
        bit       accepted;
        bit       seen;
        bit       transferred;
        cpu_req_t new_req;
        cpu_rsp_t held_rsp;
        waited      = 0;
        acc_cyc     = 0;
        first_cyc   = 0;
        accepted    = 1'b0;
        seen        = 1'b0;
        transferred = 1'b0;
        held_rsp    = '0;
        stim_lcg = lcg_next(stim_lcg);
        stall    = int'(stim_lcg[17:16]); // cycles of response back-pressure
        cur_addr       = addr;
        reads_at_issue = reads_total;
        new_req.addr   = addr;
        req_valid <= 1'b1;
        req       <= new_req;
        rsp_ready <= (stall == 0);
        while (!accepted) begin
            @(posedge clk);
            if (req_ready) begin
                accepted = 1'b1;
                acc_cyc  = cyc;
                req_valid <= 1'b0;
            end else begin
                waited = waited + 1;
                if (waited > 50) abort_run("request not accepted within 50 cycles");
            end
        end
        waited = 0;
        while (!transferred) begin
            @(posedge clk);
            check_flag("req_ready", req_ready, 1'b0); // one request outstanding
            if (rsp_valid) begin
                if (!seen) begin
                    seen      = 1'b1;
                    first_cyc = cyc;
                    held_rsp  = rsp;
                end else begin
                    check_rsp("rsp (held)", rsp, held_rsp);
                end
                if (rsp_ready) begin
                    transferred = 1'b1;
                end else begin
                    stall = stall - 1;
                    if (stall <= 0) rsp_ready <= 1'b1;
                end
            end else if (seen) begin
                abort_run("rsp_valid dropped before the response was taken");
            end else begin
                waited = waited + 1;
                if (waited > 200) abort_run("no response within 200 cycles");
            end
        end
        check_rsp("rsp", held_rsp, exp_rsp);
        if (exp_rsp.hit) begin
            if (first_cyc != acc_cyc + 1) abort_run("hit response not one cycle after acceptance");
            if (reads_total != reads_at_issue) abort_run("memory was read for a hit");
        end else if (reads_total - reads_at_issue != words_per_block) begin
            abort_run("miss did not issue exactly eight memory reads");
        end
    endtask

    initial begin : stimulus
        int          fd;
        int          n_fields;
        int          n_reqs;
        string       line;
        logic [15:0] f_addr;
        logic [15:0] f_data;
        logic        f_hit;
        cache_addr_u addr;
        cpu_rsp_t    exp_rsp;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        cur_addr  = '0;
        n_reqs    = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("verification/icache_tb_input.txt", "r");
        if (fd == 0) abort_run("cannot open verification/icache_tb_input.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line.substr(0, 0) == "#") continue; // header or blank
            n_fields = $sscanf(line, "%h %h %h", f_addr, f_data, f_hit);
            if (n_fields != 3) abort_run($sformatf("bad line in stimulus file: %s", line));
            addr.raw     = f_addr;
            exp_rsp.data = f_data;
            exp_rsp.hit  = f_hit;
            run_request(addr, exp_rsp);
            n_reqs = n_reqs + 1;
        end
        $fclose(fd);
        if (n_reqs == 0) begin
            abort_run("stimulus file held no requests");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/icache_tb_input.txt
# address  expected_data  expected_hit (hex, one request per line)
# data follows the memory rule: word at an address is address xor a5c3
1234 b7f7 0
123a b7f9 1
1230 b7f3 1
123e b7fd 1
5230 f7f3 0
523c f7ff 1
1234 b7f7 0
5232 f7f1 0
5238 f7fb 1
0000 a5c3 0
000e a5cd 1
0006 a5c5 1
fff2 5a31 0
fffe 5a3d 1
fff0 5a33 1
8e48 2b8b 0
8e40 2b83 1
8e4c 2b8f 1
123c b7ff 0
1232 b7f1 1

//--- verilog/icache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_data_array import icache_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rd_en,
    input  wire logic [index_w-1:0]  rd_index,
    input  wire logic [offset_w-1:0] rd_word,
    output logic [data_w-1:0]        rd_data,
    input  wire fill_wr_t            fill_wr
);

    // set index in the upper address bits, word offset below
    logic [data_w-1:0] mem [num_words];

    logic [index_w+offset_w-1:0] rd_addr;
    logic [index_w+offset_w-1:0] wr_addr;

    assign rd_addr = {rd_index, rd_word};
    assign wr_addr = {fill_wr.index, fill_wr.offset};

    always_ff @(posedge clk) begin
        if (fill_wr.we) begin
            mem[wr_addr] <= fill_wr.data;
        end
    end

    // registered read, output holds until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // the lookup stays off the read port while a fill is writing
    a_no_rd_during_fill: assert property (
        @(posedge clk) !(rd_en && fill_wr.we)
    ) else $error("data array read and fill write in the same cycle");

endmodule

`default_nettype wire

//--- verilog/icache_fill_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module icache_fill_fsm import icache_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              miss_detected,     // one cycle pulse from the lookup
    input  wire cache_addr_u       miss_addr,         // held by the lookup for the whole fill
    input  wire logic              memory_data_valid,
    input  wire logic [data_w-1:0] memory_data,
    output logic                   fill_busy,
    output logic                   memory_read_en,    // one word read per cycle
    output logic [addr_w-1:0]      memory_address,
    output fill_wr_t               fill_wr,
    output tag_wr_t                tag_wr
);

    logic state_q;
    logic state_d;

    // request side counts reads issued, response side counts words back
    // msb of each counter marks all eight done
    logic [offset_w:0] req_cnt_q;
    logic [offset_w:0] rsp_cnt_q;

    logic req_done;
    logic rsp_last;
    logic done;

    assign req_done = req_cnt_q[offset_w];                     // eight reads out
    assign rsp_last = (rsp_cnt_q[offset_w-1:0] == last_word);  // eighth word expected next
    assign done     = (state_q == fill_wait) && memory_data_valid && rsp_last;

    assign fill_busy      = (state_q == fill_wait);
    assign memory_read_en = (state_q == fill_wait) && !req_done;

    // block base plus word count, byte bit stays 0
    assign memory_address = {miss_addr.fields.tag, miss_addr.fields.index,
                             req_cnt_q[offset_w-1:0], 1'b0};

    // every returned word lands at the response count
    assign fill_wr.we     = (state_q == fill_wait) && memory_data_valid;
    assign fill_wr.index  = miss_addr.fields.index;
    assign fill_wr.offset = rsp_cnt_q[offset_w-1:0];
    assign fill_wr.data   = memory_data;

    // tag goes in together with the last word
    assign tag_wr.we    = done;
    assign tag_wr.index = miss_addr.fields.index;
    assign tag_wr.tag   = miss_addr.fields.tag;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fill_idle: begin
                if (miss_detected) begin
                    state_d = fill_wait;
                end
            end
            fill_wait: begin
                if (done) begin
                    state_d = fill_idle; // back to idle on the eighth word
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= fill_idle;
            req_cnt_q <= '0;
            rsp_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == fill_idle) begin
                // counters sit at zero between fills
                req_cnt_q <= '0;
                rsp_cnt_q <= '0;
            end else begin
                if (memory_read_en) begin
                    req_cnt_q <= req_cnt_q + 1'b1;
                end
                if (memory_data_valid) begin
                    rsp_cnt_q <= rsp_cnt_q + 1'b1;
                end
            end
        end
    end

    // memory only answers reads that this controller issued
    a_no_data_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == fill_idle) |-> !memory_data_valid
    ) else $error("memory data returned while fill controller idle");

    // a word can only come back for a read already sent out
    a_rsp_behind_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        memory_data_valid |-> (rsp_cnt_q < req_cnt_q)
    ) else $error("response count passed request count");

endmodule

`default_nettype wire

//--- verilog/icache_lookup.sv
`timescale 1ns/10ps
`default_nettype none

module icache_lookup import icache_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 req_valid,
    output logic                      req_ready,
    input  wire cpu_req_t             req,
    output logic                      rsp_valid,
    input  wire logic                 rsp_ready,
    output cpu_rsp_t                  rsp,
    input  wire logic                 hit,
    output logic                      rd_en,
    output logic [index_w-1:0]        rd_index,
    output logic [offset_w-1:0]       rd_word,
    input  wire logic [data_w-1:0]    rd_data,
    output logic [index_w-1:0]        lookup_index,
    output logic [tag_w-1:0]          lookup_tag,
    output logic                      miss_detected,
    output cache_addr_u               miss_addr,
    input  wire logic                 fill_busy
);

    logic [2:0]  state_q;
    logic [2:0]  state_d;
    cpu_req_t    req_q;     // held request payload
    logic        was_hit_q; // cleared once a fill was needed
    cache_addr_u rd_addr;
    logic        accept;

    assign req_ready = (state_q == lk_idle); // one request outstanding at most
    assign accept    = req_valid && req_ready;

    // read the incoming address on accept, the held one on replay
    assign rd_addr  = req_ready ? req.addr : req_q.addr;
    assign rd_en    = accept || (state_q == lk_replay);
    assign rd_index = rd_addr.fields.index;
    assign rd_word  = rd_addr.fields.offset;

    assign lookup_index = req_q.addr.fields.index;
    assign lookup_tag   = req_q.addr.fields.tag;

    assign miss_detected = (state_q == lk_compare) && !hit; // single cycle since compare is left next edge
    assign miss_addr     = req_q.addr;

    // a hit answers straight from the compare cycle
    assign rsp_valid = ((state_q == lk_compare) && hit) || (state_q == lk_resp);
    assign rsp       = '{data: rd_data, hit: was_hit_q};

    always_comb begin
        state_d = state_q;
        case (state_q)
            lk_idle: begin
                if (req_valid) begin
                    state_d = lk_compare;
                end
            end
            lk_compare: begin
                if (!hit) begin
                    state_d = lk_fill;
                end else if (!rsp_ready) begin
                    state_d = lk_resp; // park the hit response
                end else begin
                    state_d = lk_idle;
                end
            end
            lk_fill: begin
                if (!fill_busy) begin
                    state_d = lk_replay;
                end
            end
            lk_replay: state_d = lk_resp; // data captured on this edge
            lk_resp: begin
                if (rsp_ready) begin
                    state_d = lk_idle;
                end
            end
            default: state_d = lk_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= lk_idle;
            was_hit_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                was_hit_q <= 1'b1;
            end else if (miss_detected) begin
                was_hit_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // stalled response keeps its payload until the transfer
    a_rsp_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else $error("response dropped or changed under back-pressure");

endmodule

`default_nettype wire

//--- verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // basic widths
    localparam int addr_w = 16;
    localparam int data_w = 16;

    // cache geometry
    localparam int num_sets        = 32;
    localparam int words_per_block = 8;
    localparam int num_words       = num_sets * words_per_block; // total data words

    // address split derived from the geometry
    localparam int index_w  = $clog2(num_sets);            // 5
    localparam int offset_w = $clog2(words_per_block);     // 3
    localparam int tag_w    = addr_w - index_w - offset_w - 1; // 7, one byte bit below offset

    localparam logic [offset_w-1:0] last_word = offset_w'(words_per_block - 1);

    // fill controller states
    localparam logic fill_idle = 1'b0;
    localparam logic fill_wait = 1'b1;

    // lookup front end states
    localparam logic [2:0] lk_idle    = 3'd0; // ready for a request
    localparam logic [2:0] lk_compare = 3'd1; // tag compare on held request
    localparam logic [2:0] lk_fill    = 3'd2; // waiting on the fill controller
    localparam logic [2:0] lk_replay  = 3'd3; // re-read data after the fill
    localparam logic [2:0] lk_resp    = 3'd4; // holding the response

    // one address word, seen raw or as cache fields
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;   // word within the block
            logic                byte_sel; // always 0 for word reads
        } fields;
    } cache_addr_u;

    typedef struct packed {
        cache_addr_u addr;
    } cpu_req_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              hit; // 1 when served without a fill
    } cpu_rsp_t;

    // data array write from the fill controller
    typedef struct packed {
        logic                we;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
        logic [data_w-1:0]   data;
    } fill_wr_t;

    // tag array write, always marks the set valid
    typedef struct packed {
        logic               we;
        logic [index_w-1:0] index;
        logic [tag_w-1:0]   tag;
    } tag_wr_t;

endpackage

`default_nettype wire

//--- verilog/icache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array import icache_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic [index_w-1:0] lookup_index,
    input  wire logic [tag_w-1:0]   lookup_tag,
    output logic                    hit,
    input  wire tag_wr_t            tag_wr
);

    // one tag per set with the valid bits in their own vector
    logic [tag_w-1:0]    tags [num_sets];
    logic [num_sets-1:0] valid_q;

    logic [tag_w-1:0] stored_tag;
    logic             stored_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0; // cold cache
        end else if (tag_wr.we) begin
            valid_q[tag_wr.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_wr.we) begin
            tags[tag_wr.index] <= tag_wr.tag; // replaces the old block's tag
        end
    end

    // compare is purely combinational on the held lookup fields
    assign stored_tag   = tags[lookup_index];
    assign stored_valid = valid_q[lookup_index];
    assign hit          = stored_valid && (stored_tag == lookup_tag);

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top import icache_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // processor request and response
    input  wire logic              req_valid,
    output logic                   req_ready,
    input  wire cpu_req_t          req,
    output logic                   rsp_valid,
    input  wire logic              rsp_ready,
    output cpu_rsp_t               rsp,
    // main memory, no back-pressure on the return
    output logic                   memory_read_en,
    output logic [addr_w-1:0]      memory_address,
    input  wire logic              memory_data_valid,
    input  wire logic [data_w-1:0] memory_data
);

    logic                hit;
    logic                rd_en;
    logic [index_w-1:0]  rd_index;
    logic [offset_w-1:0] rd_word;
    logic [data_w-1:0]   rd_data;
    logic [index_w-1:0]  lookup_index;
    logic [tag_w-1:0]    lookup_tag;
    logic                miss_detected;
    cache_addr_u         miss_addr;
    logic                fill_busy;
    fill_wr_t            fill_wr;
    tag_wr_t             tag_wr;

    icache_lookup icache_lookup_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp),
        .hit           (hit),
        .rd_en         (rd_en),
        .rd_index      (rd_index),
        .rd_word       (rd_word),
        .rd_data       (rd_data),
        .lookup_index  (lookup_index),
        .lookup_tag    (lookup_tag),
        .miss_detected (miss_detected),
        .miss_addr     (miss_addr),
        .fill_busy     (fill_busy)
    );

    icache_tag_array icache_tag_array_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .tag_wr       (tag_wr)
    );

    icache_data_array icache_data_array_inst (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_word  (rd_word),
        .rd_data  (rd_data),
        .fill_wr  (fill_wr)
    );

    icache_fill_fsm icache_fill_fsm_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .miss_detected     (miss_detected),
        .miss_addr         (miss_addr),
        .memory_data_valid (memory_data_valid),
        .memory_data       (memory_data),
        .fill_busy         (fill_busy),
        .memory_read_en    (memory_read_en),
        .memory_address    (memory_address),
        .fill_wr           (fill_wr),
        .tag_wr            (tag_wr)
    );

endmodule

`default_nettype wire
